/* logic/cpu_consts.svh */
// Word and register widths, opcode and funct encodings, ALU command codes.
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes.
`define WORD_W     32
`define REG_ADDR_W 5
`define REG_COUNT  32

// Primary opcodes, instruction bits 31:26.
`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100

// R-type funct field, instruction bits 5:0.
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

// ALU commands.
`define ALU_AND 3'b000
`define ALU_OR  3'b001
`define ALU_ADD 3'b010
`define ALU_SUB 3'b110
`define ALU_SLT 3'b111

`endif

/* logic/cpu_pkg.sv */
// Control struct and pipeline-register struct types for the core.
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

  // Control bits produced in decode.
  typedef struct packed {
    logic       regWrite;
    logic       memToReg;
    logic       memWrite;
    logic       branch;
    logic [2:0] aluControl;
    logic       aluSrc;
    logic       regDst;
  } ctrlT;

  // Fetch to decode.
  typedef struct packed {
    logic [`WORD_W-1:0] instruction;
    logic [`WORD_W-1:0] pcPlus4;
  } ifIdT;

  // Decode to execute.
  typedef struct packed {
    ctrlT                   ctrl;
    logic [`WORD_W-1:0]     readData1;
    logic [`WORD_W-1:0]     readData2;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`WORD_W-1:0]     signImm;
    logic [`WORD_W-1:0]     pcPlus4;
  } idExT;

  // Execute to memory.
  typedef struct packed {
    logic                   regWrite;
    logic                   memToReg;
    logic                   memWrite;
    logic                   branch;
    logic                   zero;
    logic [`WORD_W-1:0]     aluOut;
    logic [`WORD_W-1:0]     writeData;
    logic [`REG_ADDR_W-1:0] writeReg;
    logic [`WORD_W-1:0]     pcBranch;
  } exMemT;

  // Memory to write-back.
  typedef struct packed {
    logic                   regWrite;
    logic                   memToReg;
    logic [`WORD_W-1:0]     aluOut;
    logic [`WORD_W-1:0]     readData;
    logic [`REG_ADDR_W-1:0] writeReg;
  } memWbT;

  // Write-back bus into the register file.
  typedef struct packed {
    logic                   regWrite;
    logic [`REG_ADDR_W-1:0] writeReg;
    logic [`WORD_W-1:0]     result;
  } wbT;

endpackage

`default_nettype wire

/* logic/alu.sv */
// ALU with and, or, add, sub and signed set-less-than, plus a zero flag.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module alu (
  input  logic [`WORD_W-1:0] operandA,
  input  logic [`WORD_W-1:0] operandB,
  input  logic [2:0]         command,
  output logic [`WORD_W-1:0] result,
  output logic               zero
);

  always_comb begin
    case (command)
      `ALU_AND: result = operandA & operandB;
      `ALU_OR:  result = operandA | operandB;
      `ALU_ADD: result = operandA + operandB;
      `ALU_SUB: result = operandA - operandB;
      // Signed compare, result is 0 or 1.
      `ALU_SLT: begin
        result = '0;
        result[0] = $signed(operandA) < $signed(operandB);
      end
      default:  result = '0;
    endcase
  end

  // Used by beq after a subtract.
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/regFile.sv */
// Register file, 32 entries, register zero fixed at zero, write-through reads.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module regFile (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] readReg1,
  input  logic [`REG_ADDR_W-1:0] readReg2,
  output logic [`WORD_W-1:0]     readData1,
  output logic [`WORD_W-1:0]     readData2,
  input  cpu_pkg::wbT            wb
);

  logic [`WORD_W-1:0] regs [`REG_COUNT];

  // Register zero is never written.
  always_ff @(posedge clk) begin
    if (wb.regWrite && (wb.writeReg != '0)) begin
      regs[wb.writeReg] <= wb.result;
    end
  end

  // Bypass the write in progress so decode sees it this cycle.
  function automatic logic [`WORD_W-1:0] readPort(input logic [`REG_ADDR_W-1:0] idx);
    logic [`WORD_W-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (wb.regWrite && (wb.writeReg == idx)) begin
      value = wb.result;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    readData1 = readPort(readReg1);
    readData2 = readPort(readReg2);
  end

endmodule

`default_nettype wire

/* logic/controlDecoder.sv */
// Main control decoder from opcode and funct to the control struct.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module controlDecoder (
  input  logic [5:0]    opcode,
  input  logic [5:0]    funct,
  output cpu_pkg::ctrlT ctrl
);

  always_comb begin
    ctrl = '0;
    case (opcode)
      `OP_RTYPE: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (funct)
          `FN_ADD: ctrl.aluControl = `ALU_ADD;
          `FN_SUB: ctrl.aluControl = `ALU_SUB;
          `FN_AND: ctrl.aluControl = `ALU_AND;
          `FN_OR:  ctrl.aluControl = `ALU_OR;
          `FN_SLT: ctrl.aluControl = `ALU_SLT;
          // Unsupported funct, including the sll nop.
          default: ctrl = '0;
        endcase
      end
      `OP_ADDI: begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrc     = 1'b1;
        ctrl.aluControl = `ALU_ADD;
      end
      `OP_LW: begin
        ctrl.regWrite   = 1'b1;
        ctrl.memToReg   = 1'b1;
        ctrl.aluSrc     = 1'b1;
        ctrl.aluControl = `ALU_ADD;
      end
      `OP_SW: begin
        ctrl.memWrite   = 1'b1;
        ctrl.aluSrc     = 1'b1;
        ctrl.aluControl = `ALU_ADD;
      end
      // Compare by subtraction, taken on zero.
      `OP_BEQ: begin
        ctrl.branch     = 1'b1;
        ctrl.aluControl = `ALU_SUB;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/fetchStage.sv */
// Program counter, next-PC select and the fetch-to-decode register.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module fetchStage (
  input  logic               clk,
  input  logic               arstN,
  input  cpu_pkg::exMemT     exMem,
  output logic [`WORD_W-1:0] pc,
  input  logic [`WORD_W-1:0] instruction,
  output cpu_pkg::ifIdT      ifId
);

  logic [`WORD_W-1:0] pcPlus4;
  logic [`WORD_W-1:0] pcNext;
  logic               branchTaken;

  assign pcPlus4 = pc + `WORD_W'(4);

  // Branch resolves in the memory stage.
  assign branchTaken = exMem.branch & exMem.zero;
  assign pcNext      = branchTaken ? exMem.pcBranch : pcPlus4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // Reset loads a nop.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ifId <= '0;
    end else begin
      ifId.instruction <= instruction;
      ifId.pcPlus4     <= pcPlus4;
    end
  end

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
// Control decode, register read, sign extension and the decode-to-execute register.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module decodeStage (
  input  logic          clk,
  input  logic          arstN,
  input  cpu_pkg::ifIdT ifId,
  input  cpu_pkg::wbT   wb,
  output cpu_pkg::idExT idEx
);

  import cpu_pkg::*;

  ctrlT               ctrl;
  logic [`WORD_W-1:0] readData1;
  logic [`WORD_W-1:0] readData2;
  logic [`WORD_W-1:0] signImm;

  controlDecoder uDecoder (
    .opcode (ifId.instruction[31:26]),
    .funct  (ifId.instruction[5:0]),
    .ctrl   (ctrl)
  );

  regFile uRegs (
    .clk       (clk),
    .readReg1  (ifId.instruction[25:21]),
    .readReg2  (ifId.instruction[20:16]),
    .readData1 (readData1),
    .readData2 (readData2),
    .wb        (wb)
  );

  // 16-bit immediate to a full word.
  assign signImm = {{(`WORD_W-16){ifId.instruction[15]}}, ifId.instruction[15:0]};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else begin
      idEx.ctrl      <= ctrl;
      idEx.readData1 <= readData1;
      idEx.readData2 <= readData2;
      idEx.rt        <= ifId.instruction[20:16];
      idEx.rd        <= ifId.instruction[15:11];
      idEx.signImm   <= signImm;
      idEx.pcPlus4   <= ifId.pcPlus4;
    end
  end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
// Operand select, ALU, branch target, destination select and the execute-to-memory register.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module executeStage (
  input  logic           clk,
  input  logic           arstN,
  input  cpu_pkg::idExT  idEx,
  output cpu_pkg::exMemT exMem
);

  import cpu_pkg::*;

  exMemT              exNext;
  logic [`WORD_W-1:0] srcB;
  logic [`WORD_W-1:0] aluOut;
  logic               zero;

  // Immediate for addi, lw and sw.
  assign srcB = idEx.ctrl.aluSrc ? idEx.signImm : idEx.readData2;

  alu uAlu (
    .operandA (idEx.readData1),
    .operandB (srcB),
    .command  (idEx.ctrl.aluControl),
    .result   (aluOut),
    .zero     (zero)
  );

  always_comb begin
    exNext.regWrite  = idEx.ctrl.regWrite;
    exNext.memToReg  = idEx.ctrl.memToReg;
    exNext.memWrite  = idEx.ctrl.memWrite;
    exNext.branch    = idEx.ctrl.branch;
    exNext.zero      = zero;
    exNext.aluOut    = aluOut;
    exNext.writeData = idEx.readData2;
    // rd for R-type, rt otherwise.
    exNext.writeReg  = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
    // Word offset relative to the delay slot.
    exNext.pcBranch  = idEx.pcPlus4 + {idEx.signImm[`WORD_W-3:0], 2'b00};
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem <= exNext;
    end
  end

endmodule

`default_nettype wire

/* logic/writebackStage.sv */
// Memory-to-write-back register and result select.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module writebackStage (
  input  logic               clk,
  input  logic               arstN,
  input  cpu_pkg::exMemT     exMem,
  input  logic [`WORD_W-1:0] dataIn,
  output cpu_pkg::wbT        wb
);

  import cpu_pkg::*;

  memWbT memWb;

  // Captures the loaded word at the end of the memory stage.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWb <= '0;
    end else begin
      memWb.regWrite <= exMem.regWrite;
      memWb.memToReg <= exMem.memToReg;
      memWb.aluOut   <= exMem.aluOut;
      memWb.readData <= dataIn;
      memWb.writeReg <= exMem.writeReg;
    end
  end

  assign wb.regWrite = memWb.regWrite;
  assign wb.writeReg = memWb.writeReg;
  assign wb.result   = memWb.memToReg ? memWb.readData : memWb.aluOut;

endmodule

`default_nettype wire

/* logic/cpuCore.sv */
// Top level of the five-stage core with instruction and data memory ports.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpuCore (
  input  logic               clk,
  input  logic               arstN,
  output logic [`WORD_W-1:0] instrAddr,
  input  logic [`WORD_W-1:0] instruction,
  output logic [`WORD_W-1:0] dataAddr,
  output logic [`WORD_W-1:0] dataOut,
  output logic               memWrite,
  input  logic [`WORD_W-1:0] dataIn
);

  import cpu_pkg::*;

  ifIdT  ifId;
  idExT  idEx;
  exMemT exMem;
  wbT    wb;

  fetchStage uFetch (
    .clk         (clk),
    .arstN       (arstN),
    .exMem       (exMem),
    .pc          (instrAddr),
    .instruction (instruction),
    .ifId        (ifId)
  );

  decodeStage uDecode (
    .clk   (clk),
    .arstN (arstN),
    .ifId  (ifId),
    .wb    (wb),
    .idEx  (idEx)
  );

  executeStage uExecute (
    .clk   (clk),
    .arstN (arstN),
    .idEx  (idEx),
    .exMem (exMem)
  );

  writebackStage uWriteback (
    .clk    (clk),
    .arstN  (arstN),
    .exMem  (exMem),
    .dataIn (dataIn),
    .wb     (wb)
  );

  // Memory stage is the data port itself.
  assign dataAddr = exMem.aluOut;
  assign dataOut  = exMem.writeData;
  assign memWrite = exMem.memWrite;

endmodule

`default_nettype wire

/* test/cpuCore_sva.sv */
// Bound assertions on reset state, branch redirection and store port values.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpuCore_sva (
  input logic               clk,
  input logic               arstN,
  input logic [`WORD_W-1:0] instrAddr,
  input logic [`WORD_W-1:0] dataAddr,
  input logic [`WORD_W-1:0] dataOut,
  input logic               memWrite,
  input cpu_pkg::exMemT     exMem
);

  // PC and store enable held clear during reset.
  resetState: assert property (@(posedge clk) !arstN |-> (instrAddr == '0) && !memWrite)
    else $error("instrAddr or memWrite not cleared during reset");

  // Taken beq in the memory stage redirects the next fetch.
  branchRedirect: assert property (@(posedge clk) disable iff (!arstN)
      arstN && exMem.branch && exMem.zero |=> instrAddr == $past(exMem.pcBranch))
    else $error("fetch did not follow the taken branch target");

  sequentialFetch: assert property (@(posedge clk) disable iff (!arstN)
      arstN && !(exMem.branch && exMem.zero) |=> instrAddr == $past(instrAddr) + `WORD_W'(4))
    else $error("fetch address did not advance by one word");

  // Store port comes straight from the execute-to-memory register.
  storePortKnown: assert property (@(posedge clk) disable iff (!arstN)
      memWrite |-> !$isunknown({dataAddr, dataOut}))
    else $error("store address or data unknown during a write");

endmodule

bind cpuCore cpuCore_sva uSva (
  .clk       (clk),
  .arstN     (arstN),
  .instrAddr (instrAddr),
  .dataAddr  (dataAddr),
  .dataOut   (dataOut),
  .memWrite  (memWrite),
  .exMem     (exMem)
);

`default_nettype wire

/* test/cpuCore_tb.sv */
// Testbench for the core with clock, reset, random program, ISA model, memories and checks.
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpuCore_tb;

  localparam int MEM_WORDS = 1024;
  localparam int BODY_OPS  = 80;

  typedef struct packed {
    logic [`WORD_W-1:0] addr;
    logic [`WORD_W-1:0] data;
  } storeT;

  logic               clk;
  logic               arstN;
  logic               running;
  logic [`WORD_W-1:0] instrAddr;
  logic [`WORD_W-1:0] instruction;
  logic [`WORD_W-1:0] dataAddr;
  logic [`WORD_W-1:0] dataOut;
  logic               memWrite;
  logic [`WORD_W-1:0] dataIn;

  logic [`WORD_W-1:0] instrMem [MEM_WORDS];
  logic [`WORD_W-1:0] dataMem [MEM_WORDS];
  logic [`WORD_W-1:0] modelMem [MEM_WORDS];
  logic [`WORD_W-1:0] expFetch [$];
  storeT              expStores [$];
  int                 progWords;
  int                 watchdogNs;

  cpuCore u_dut (
    .clk         (clk),
    .arstN       (arstN),
    .instrAddr   (instrAddr),
    .instruction (instruction),
    .dataAddr    (dataAddr),
    .dataOut     (dataOut),
    .memWrite    (memWrite),
    .dataIn      (dataIn)
  );

  // Both memories answer in the same cycle.
  assign instruction = instrMem[instrAddr[11:2]];
  assign dataIn      = dataMem[dataAddr[11:2]];

  always @(posedge clk) begin
    if (arstN && memWrite === 1'b1) begin
      dataMem[dataAddr[11:2]] <= dataOut;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Background data derived from the full byte address.
  function automatic logic [`WORD_W-1:0] fillWord(input int idx);
    logic [`WORD_W-1:0] addr;
    addr = idx * 4;
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
  endfunction

  function automatic logic [`WORD_W-1:0] encR(input logic [5:0] funct,
                                              input logic [4:0] rd, rs, rt);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [`WORD_W-1:0] encI(input logic [5:0] op, input logic [4:0] rt, rs,
                                              input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // One instruction followed by three nops from the cleared memory.
  task automatic emitGroup(input logic [`WORD_W-1:0] instr);
    instrMem[progWords] = instr;
    progWords = progWords + 4;
  endtask

  task automatic buildProgram();
    logic [31:0]        rnd;
    logic [4:0]         rs, rt, rd;
    logic [15:0]        imm, memImm;
    logic [`WORD_W-1:0] instr;
    int                 kind, skip;
    progWords = 0;
    // r28 is the data base pointer at 0x800.
    for (int k = 1; k < 32; k++) begin
      rnd = $urandom;
      imm = (k == 28) ? 16'h0800 : rnd[15:0];
      emitGroup(encI(`OP_ADDI, k[4:0], 5'd0, imm));
    end
    emitGroup(encI(`OP_ADDI, 5'd0, 5'd1, 16'h1234));
    for (int i = 0; i < BODY_OPS; i++) begin
      rnd    = $urandom;
      kind   = $urandom % 9;
      rs     = rnd[4:0];
      rt     = rnd[9:5];
      rd     = (rnd[14:10] == 5'd28) ? 5'd0 : rnd[14:10];
      imm    = rnd[31:16];
      memImm = {{4{rnd[27]}}, rnd[27:18], 2'b00};
      case (kind)
        0: instr = encR(`FN_ADD, rd, rs, rt);
        1: instr = encR(`FN_SUB, rd, rs, rt);
        2: instr = encR(`FN_AND, rd, rs, rt);
        3: instr = encR(`FN_OR, rd, rs, rt);
        4: instr = encR(`FN_SLT, rd, rs, rt);
        5: instr = encI(`OP_ADDI, rd, rs, imm);
        6: instr = encI(`OP_LW, rd, 5'd28, memImm);
        7: instr = encI(`OP_SW, rt, 5'd28, memImm);
        default: begin
          // Forward branch over zero to two later groups.
          skip = $urandom % 3;
          if (i + skip >= BODY_OPS) begin
            skip = 0;
          end
          instr = encI(`OP_BEQ, rnd[15] ? rs : rt, rs, 16'(3 + 4 * skip));
        end
      endcase
      emitGroup(instr);
    end
    // Register dump to addresses 0 through 0x7C.
    for (int k = 0; k < 32; k++) begin
      emitGroup(encI(`OP_SW, k[4:0], 5'd28, 16'hF800 + 16'(4 * k)));
    end
  endtask

  // Instruction-level model with three delay slots after a taken beq.
  task automatic runModel();
    logic [`WORD_W-1:0] regs [32];
    logic [`WORD_W-1:0] pc, nextPc, target, instr, a, b, imm, addr;
    logic [4:0]         rt, rd;
    int                 countdown;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    pc        = '0;
    target    = '0;
    countdown = 0;
    while (pc < 32'(progWords * 4)) begin
      instr  = instrMem[pc[11:2]];
      rt     = instr[20:16];
      rd     = instr[15:11];
      a      = regs[instr[25:21]];
      b      = regs[rt];
      imm    = {{16{instr[15]}}, instr[15:0]};
      addr   = a + imm;
      nextPc = pc + 4;
      expFetch.push_back(pc);
      if (countdown > 0) begin
        countdown = countdown - 1;
        if (countdown == 0) begin
          nextPc = target;
        end
      end
      case (instr[31:26])
        `OP_RTYPE: begin
          case (instr[5:0])
            `FN_ADD: regs[rd] = a + b;
            `FN_SUB: regs[rd] = a - b;
            `FN_AND: regs[rd] = a & b;
            `FN_OR:  regs[rd] = a | b;
            `FN_SLT: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        `OP_ADDI: regs[rt] = addr;
        `OP_LW:   regs[rt] = modelMem[addr[11:2]];
        `OP_SW: begin
          modelMem[addr[11:2]] = b;
          expStores.push_back({addr, b});
        end
        `OP_BEQ: begin
          if (a == b) begin
            countdown = 3;
            target    = pc + 4 + {imm[29:0], 2'b00};
          end
        end
        default: ;
      endcase
      regs[0] = '0;
      pc      = nextPc;
    end
  endtask

  task automatic failRun();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic checkFetch(input logic [`WORD_W-1:0] addr);
    logic [`WORD_W-1:0] exp;
    exp = expFetch.pop_front();
    if (addr !== exp) begin
      $display("MISMATCH time=%0t signal=instrAddr expected=%h actual=%h", $time, exp, addr);
      failRun();
    end
  endtask

  task automatic checkStore(input logic [`WORD_W-1:0] addr, input logic [`WORD_W-1:0] data);
    storeT exp;
    exp = expStores.pop_front();
    if (addr !== exp.addr) begin
      $display("MISMATCH time=%0t signal=dataAddr expected=%h actual=%h", $time, exp.addr, addr);
      failRun();
    end else if (data !== exp.data) begin
      $display("MISMATCH time=%0t signal=dataOut expected=%h actual=%h", $time, exp.data, data);
      failRun();
    end
  endtask

  // Outputs are sampled mid-cycle.
  always @(negedge clk) begin
    if (running && expFetch.size() > 0) begin
      checkFetch(instrAddr);
    end
  end

  always @(negedge clk) begin
    if (running && memWrite !== 1'b0) begin
      if (memWrite !== 1'b1) begin
        $display("ERROR: memWrite is unknown at time %0t", $time);
        failRun();
      end else if (expStores.size() == 0) begin
        $display("ERROR: unexpected store at time %0t after the last expected one", $time);
        failRun();
      end else begin
        checkStore(dataAddr, dataOut);
      end
    end
  end

  initial begin
    wait (watchdogNs != 0);
    #(watchdogNs);
    $display("ERROR: program did not finish within %0d ns", watchdogNs);
    failRun();
  end

  initial begin
    int seedDummy;
    arstN      = 1'b0;
    running    = 1'b0;
    watchdogNs = 0;
    seedDummy  = $urandom(33);
    for (int i = 0; i < MEM_WORDS; i++) begin
      instrMem[i] = '0;
      dataMem[i]  = fillWord(i);
      modelMem[i] = fillWord(i);
    end
    buildProgram();
    runModel();
    // One fetch per cycle plus reset and a drain margin.
    watchdogNs = (8 + expFetch.size() + 40) * 10;
    repeat (8) @(posedge clk);
    arstN   <= 1'b1;
    running <= 1'b1;
    while (expFetch.size() != 0 || expStores.size() != 0) begin
      @(posedge clk);
    end
    // Drain the pipeline so a trailing extra store is still caught.
    repeat (4) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/regFile.sv
logic/controlDecoder.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/cpuCore.sv
test/cpuCore_sva.sv
test/cpuCore_tb.sv
